// File: hw/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WAYS           = 4;
    localparam int SETS           = 128;
    localparam int INDEX_W        = 7;
    localparam int TAG_W          = 20;
    localparam int OFFSET_W       = 5;
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_SEL_W     = 3;
    localparam int PLRU_W         = 3;

    // Fetch view of an address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } icache_lookup_t;

    // Index-invalidate view, way number sits in bits 13:12
    typedef struct packed {
        logic [ADDR_W-INDEX_W-OFFSET_W-3:0] unused;
        logic [1:0]                         way;
        logic [INDEX_W-1:0]                 index;
        logic [OFFSET_W-1:0]                offset;
    } icache_op_addr_t;

    typedef union packed {
        icache_lookup_t  fetch;
        icache_op_addr_t op;
    } icache_addr_u;

    // One-hot way, all zero means no write
    typedef struct packed {
        logic [WAYS-1:0]    way;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        logic               valid;
    } tag_write_t;

    typedef struct packed {
        logic [WAYS-1:0]       way;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word;
        logic [WORD_W-1:0]     data;
    } data_write_t;

    ////////////////////////////////////////
    // Tree PLRU, bits are {b2, b1, b0}
    ////////////////////////////////////////
    function automatic logic [WAYS-1:0] plru_victim(input logic [PLRU_W-1:0] bits);
        if (!bits[2]) begin
            return bits[1] ? 4'b0010 : 4'b0001;
        end
        return bits[0] ? 4'b1000 : 4'b0100;
    endfunction

    // Point the tree away from the way just used
    function automatic logic [PLRU_W-1:0] plru_update(input logic [PLRU_W-1:0] bits,
                                                      input logic [WAYS-1:0]   way);
        logic [PLRU_W-1:0] next;
        next = bits;
        case (way)
            4'b0001: next[2:1] = 2'b11;
            4'b0010: next[2:1] = 2'b10;
            4'b0100: {next[2], next[0]} = 2'b01;
            4'b1000: {next[2], next[0]} = 2'b00;
            default: next = bits;
        endcase
        return next;
    endfunction

endpackage

// File: hw/icache_tag_array.sv
module icache_tag_array (
    input  logic                           clk,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    input  logic [icache_pkg::TAG_W-1:0]   rd_tag,
    input  icache_pkg::tag_write_t         wr,
    output logic [icache_pkg::WAYS-1:0]    hit
);

    // Lookup tag follows the read by one cycle
    logic [icache_pkg::TAG_W-1:0] cmp_tag_q;

    always_ff @(posedge clk) begin
        cmp_tag_q <= rd_tag;
    end

    ////////////////////////////////////////
    // One tag/valid RAM per way
    ////////////////////////////////////////
    generate
        for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
            logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::SETS];
            logic                         valid_mem [icache_pkg::SETS];
            logic [icache_pkg::TAG_W-1:0] tag_q;
            logic                         valid_q;

            always_ff @(posedge clk) begin
                if (wr.way[w]) begin
                    tag_mem[wr.index]   <= wr.tag;
                    valid_mem[wr.index] <= wr.valid;
                end
            end

            // Read returns the old entry on a same-set write
            always_ff @(posedge clk) begin
                tag_q   <= tag_mem[rd_index];
                valid_q <= valid_mem[rd_index];
            end

            assign hit[w] = valid_q && (tag_q == cmp_tag_q);
        end
    endgenerate

endmodule

// File: hw/icache_data_array.sv
module icache_data_array (
    input  logic                              clk,
    input  logic [icache_pkg::INDEX_W-1:0]    rd_index,
    input  logic [icache_pkg::WORD_SEL_W-1:0] rd_word,
    input  icache_pkg::data_write_t           wr,
    output logic [icache_pkg::WAYS-1:0][icache_pkg::WORD_W-1:0] rd_data
);

    // Word address inside a way, {set, word}
    logic [icache_pkg::INDEX_W+icache_pkg::WORD_SEL_W-1:0] rd_addr;
    logic [icache_pkg::INDEX_W+icache_pkg::WORD_SEL_W-1:0] wr_addr;

    assign rd_addr = {rd_index, rd_word};
    assign wr_addr = {wr.index, wr.word};

    ////////////////////////////////////////
    // Line storage, one word wide per way
    ////////////////////////////////////////
    generate
        for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
            logic [icache_pkg::WORD_W-1:0] mem [icache_pkg::SETS*icache_pkg::WORDS_PER_LINE];
            logic [icache_pkg::WORD_W-1:0] rd_q;

            // Refill writes one beat at a time
            always_ff @(posedge clk) begin
                if (wr.way[w]) begin
                    mem[wr_addr] <= wr.data;
                end
            end

            always_ff @(posedge clk) begin
                rd_q <= mem[rd_addr];
            end

            assign rd_data[w] = rd_q;
        end
    endgenerate

endmodule

// File: hw/icache_plru.sv
module icache_plru (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [icache_pkg::INDEX_W-1:0] index,
    input  logic                           clear,
    input  logic                           touch,
    input  logic [icache_pkg::WAYS-1:0]    touch_way,
    input  logic [icache_pkg::INDEX_W-1:0] touch_index,
    output logic [icache_pkg::WAYS-1:0]    victim
);

    // Tree bits for every set, cleared by the reset sweep
    logic [icache_pkg::PLRU_W-1:0] tree [icache_pkg::SETS];
    logic [icache_pkg::PLRU_W-1:0] touch_bits;
    logic [icache_pkg::PLRU_W-1:0] lookup_bits;

    assign touch_bits  = tree[touch_index];
    assign lookup_bits = tree[index];

    ////////////////////////////////////////
    // Tree update
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (clear) begin
            tree[index] <= '0;
        end else if (touch) begin
            tree[touch_index] <= icache_pkg::plru_update(touch_bits, touch_way);
        end
    end

    ////////////////////////////////////////
    // Victim for the looked-up set
    ////////////////////////////////////////
    // Ready one cycle after the index is presented
    always_ff @(posedge clk) begin
        if (!rstn) begin
            victim <= '0;
        end else begin
            victim <= icache_pkg::plru_victim(lookup_bits);
        end
    end

endmodule

// File: hw/icache_ctrl.sv
module icache_ctrl (
    input  logic                              clk,
    input  logic                              rstn,
    // Fetch port
    input  logic                              inst_req,
    input  icache_pkg::icache_addr_u          inst_addr,
    output logic                              inst_addr_ok,
    output logic                              inst_data_ok,
    output logic [icache_pkg::WORD_W-1:0]     inst_rdata,
    // Maintenance
    input  logic                              cache_req,
    output logic                              cache_op_ok,
    // Read bus
    output logic [icache_pkg::ADDR_W-1:0]     araddr,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [icache_pkg::WORD_W-1:0]     rdata,
    input  logic                              rvalid,
    input  logic                              rlast,
    output logic                              rready,
    // Arrays and PLRU
    input  logic [icache_pkg::WAYS-1:0]       hit,
    input  logic [icache_pkg::WAYS-1:0][icache_pkg::WORD_W-1:0] rd_data,
    input  logic [icache_pkg::WAYS-1:0]       victim,
    output icache_pkg::tag_write_t            tag_wr,
    output icache_pkg::data_write_t           data_wr,
    output logic [icache_pkg::INDEX_W-1:0]    lookup_index,
    output logic [icache_pkg::TAG_W-1:0]      lookup_tag,
    output logic [icache_pkg::WORD_SEL_W-1:0] lookup_word,
    output logic                              plru_clear,
    output logic                              plru_touch,
    output logic [icache_pkg::WAYS-1:0]       plru_touch_way,
    output logic [icache_pkg::INDEX_W-1:0]    plru_touch_index
);

    typedef enum logic [2:0] {
        ST_SWEEP, ST_RUN, ST_MISS, ST_REFILL, ST_RESPOND, ST_INVAL
    } state_t;

    state_t                            state;
    logic [icache_pkg::INDEX_W-1:0]    sweep_cnt;
    logic                              pend_valid;
    icache_pkg::icache_lookup_t        pend_addr;
    logic [icache_pkg::WORD_SEL_W-1:0] pend_word;
    logic [icache_pkg::WAYS-1:0]       refill_way;
    logic [icache_pkg::WORD_SEL_W-1:0] refill_word;
    logic [icache_pkg::WORD_W-1:0]     crit_word;
    logic [icache_pkg::WORD_W-1:0]     hit_word;
    logic [icache_pkg::WAYS-1:0]       op_way_sel;
    logic                              hit_any;
    logic                              ready;
    logic                              accept;
    logic                              inval_take;
    logic                              beat;

    assign pend_word = pend_addr.offset[icache_pkg::OFFSET_W-1:2];
    assign hit_any   = |hit;
    assign beat      = (state == ST_REFILL) && rvalid;

    ////////////////////////////////////////
    // Acceptance and responses
    ////////////////////////////////////////
    // Ready when nothing is in lookup or the lookup hits
    assign ready        = (state == ST_RUN) && (!pend_valid || hit_any);
    assign inval_take   = ready && cache_req && !cache_op_ok;
    assign inst_addr_ok = ready && !cache_req;
    assign accept       = inst_addr_ok && inst_req;

    assign inst_data_ok = ((state == ST_RUN) && pend_valid && hit_any) ||
                          (state == ST_RESPOND);
    assign inst_rdata   = (state == ST_RESPOND) ? crit_word : hit_word;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (hit[w]) begin
                hit_word = hit_word | rd_data[w];
            end
        end
    end

    // Array read address, the new request or the one held
    always_comb begin
        if (state == ST_SWEEP) begin
            lookup_index = sweep_cnt;
        end else if (accept) begin
            lookup_index = inst_addr.fetch.index;
        end else begin
            lookup_index = pend_addr.index;
        end
        lookup_tag  = accept ? inst_addr.fetch.tag : pend_addr.tag;
        lookup_word = accept ? inst_addr.fetch.offset[icache_pkg::OFFSET_W-1:2] : pend_word;
    end

    // PLRU sees every completed fetch
    assign plru_clear       = (state == ST_SWEEP);
    assign plru_touch       = inst_data_ok;
    assign plru_touch_way   = (state == ST_RESPOND) ? refill_way : hit;
    assign plru_touch_index = pend_addr.index;

    ////////////////////////////////////////
    // Read bus and array writes
    ////////////////////////////////////////
    assign araddr  = {pend_addr[icache_pkg::ADDR_W-1:2], 2'b00};
    assign arvalid = (state == ST_MISS);
    assign rready  = (state == ST_REFILL);

    always_comb begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            op_way_sel[w] = (inst_addr.op.way == w);
        end
    end

    always_comb begin
        tag_wr = '0;
        if (state == ST_SWEEP) begin
            tag_wr.way   = '1;
            tag_wr.index = sweep_cnt;
        end else if (beat && rlast) begin
            tag_wr.way   = refill_way;
            tag_wr.index = pend_addr.index;
            tag_wr.tag   = pend_addr.tag;
            tag_wr.valid = 1'b1;
        end else if (inval_take) begin
            tag_wr.way   = op_way_sel;
            tag_wr.index = inst_addr.op.index;
        end
    end

    assign data_wr.way   = beat ? refill_way : '0;
    assign data_wr.index = pend_addr.index;
    assign data_wr.word  = refill_word;
    assign data_wr.data  = rdata;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= ST_SWEEP;
            sweep_cnt   <= '0;
            pend_valid  <= 1'b0;
            cache_op_ok <= 1'b0;
        end else begin
            cache_op_ok <= (state == ST_INVAL);
            case (state)
                ST_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == icache_pkg::SETS - 1) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (pend_valid && !hit_any) begin
                        state <= ST_MISS;
                    end else begin
                        pend_valid <= accept;
                        if (inval_take) begin
                            state <= ST_INVAL;
                        end
                    end
                end
                ST_MISS: begin
                    if (arready) begin
                        state <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (rvalid && rlast) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    pend_valid <= 1'b0;
                    state      <= ST_RUN;
                end
                default: state <= ST_RUN;
            endcase
        end
    end

    // Request address, victim and critical word
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr <= inst_addr.fetch;
        end
        if (state == ST_MISS) begin
            refill_way  <= victim;
            refill_word <= pend_word;
        end
        if (beat) begin
            refill_word <= refill_word + 1'b1;
            if (refill_word == pend_word) begin
                crit_word <= rdata;
            end
        end
    end

endmodule

// File: hw/icache_top.sv
module icache_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          inst_req,
    input  icache_pkg::icache_addr_u      inst_addr,
    output logic                          inst_addr_ok,
    output logic                          inst_data_ok,
    output logic [icache_pkg::WORD_W-1:0] inst_rdata,
    input  logic                          cache_req,
    output logic                          cache_op_ok,
    output logic [icache_pkg::ADDR_W-1:0] araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [icache_pkg::WORD_W-1:0] rdata,
    input  logic                          rvalid,
    input  logic                          rlast,
    output logic                          rready
);

    logic [icache_pkg::WAYS-1:0]                        hit;
    logic [icache_pkg::WAYS-1:0][icache_pkg::WORD_W-1:0] rd_data;
    logic [icache_pkg::WAYS-1:0]                        victim;
    icache_pkg::tag_write_t                             tag_wr;
    icache_pkg::data_write_t                            data_wr;
    logic [icache_pkg::INDEX_W-1:0]                     lookup_index;
    logic [icache_pkg::TAG_W-1:0]                       lookup_tag;
    logic [icache_pkg::WORD_SEL_W-1:0]                  lookup_word;
    logic                                               plru_clear;
    logic                                               plru_touch;
    logic [icache_pkg::WAYS-1:0]                        plru_touch_way;
    logic [icache_pkg::INDEX_W-1:0]                     plru_touch_index;

    icache_ctrl u_ctrl (.*);

    icache_tag_array u_tag (
        .clk      (clk),
        .rd_index (lookup_index),
        .rd_tag   (lookup_tag),
        .wr       (tag_wr),
        .hit      (hit)
    );

    icache_data_array u_data (
        .clk      (clk),
        .rd_index (lookup_index),
        .rd_word  (lookup_word),
        .wr       (data_wr),
        .rd_data  (rd_data)
    );

    icache_plru u_plru (
        .clk         (clk),
        .rstn        (rstn),
        .index       (lookup_index),
        .clear       (plru_clear),
        .touch       (plru_touch),
        .touch_way   (plru_touch_way),
        .touch_index (plru_touch_index),
        .victim      (victim)
    );

endmodule

// File: tb/icache_tb.sv
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int N_FETCH    = 600;
    localparam int INVAL_GAP  = 30;
    localparam int SEED       = 32'h3b89ed20;

    logic        clk = 1'b0;
    logic        rstn;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    logic        cache_req;
    logic        cache_op_ok;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rlast;
    logic        rready;

    // Reference model, one entry per set and way
    logic [19:0] m_tag [128][4];
    bit          m_valid [128][4];
    logic [2:0]  m_plru [128];

    // Outstanding fetches in request order
    logic [31:0] q_addr [$];
    bit          q_hit [$];
    int          q_cyc [$];

    int          errors, misses, bursts, invals, issued, cyc, inval_cyc, beats;
    bit          want_inval, ar_seen, burst_on;
    logic [31:0] burst_base;

    icache_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e3779b1);
    endfunction

    // Few sets and six tags per set, so lines get evicted
    function automatic logic [31:0] fetch_addr();
        logic [19:0] tag;
        logic [6:0]  index;
        tag   = 20'h00c40 + 20'($urandom % 6);
        index = 7'(($urandom % 4) * 29);
        return {tag, index, 3'($urandom), 2'b00};
    endfunction

    function automatic int choose_victim(input logic [2:0] b);
        if (!b[2]) begin
            return b[1] ? 1 : 0;
        end
        return b[0] ? 3 : 2;
    endfunction

    function automatic logic [2:0] tree_after_access(input logic [2:0] b, input int way);
        case (way)
            0:       b[2:1] = 2'b11;
            1:       b[2:1] = 2'b10;
            2:       {b[2], b[0]} = 2'b01;
            default: {b[2], b[0]} = 2'b00;
        endcase
        return b;
    endfunction

    // Predicts hit or miss, a miss fills the victim way
    function automatic bit model_access(input logic [31:0] addr);
        logic [6:0]  set;
        logic [19:0] tag;
        int          way;
        bit          hit;
        set = addr[11:5];
        tag = addr[31:12];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = choose_victim(m_plru[set]);
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
        end
        m_plru[set] = tree_after_access(m_plru[set], way);
        return hit;
    endfunction

    ////////////////////////////////////////
    // AXI read slave, wrapping burst
    ////////////////////////////////////////
    task automatic serve_read_bus();
        if (rvalid && !rready) begin
            $display("** Error at %0t: read beat offered while rready is low", $time);
            errors++;
        end
        if (rvalid && rready) begin
            beats++;
            if (rlast) begin
                burst_on = 1'b0;
            end
        end
        if (arvalid && arready) begin
            burst_on   = 1'b1;
            burst_base = araddr;
            beats      = 0;
        end
        // Random gaps in rvalid
        if (burst_on && ($urandom % 3 != 0)) begin
            rvalid <= 1'b1;
            rdata  <= mem_word({burst_base[31:5], 3'(burst_base[4:2] + beats), 2'b00});
            rlast  <= (beats == 7);
        end else begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end
        arready <= ($urandom % 2 == 0);
    endtask

    initial begin
        #(N_FETCH * 2000 * CLK_PERIOD);
        $display("** Error at %0t: watchdog expired, the DUT stopped responding", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] op;
        bit          hit;
        bit          acc;
        int          acc_cyc;
        void'($urandom(SEED));
        rstn      = 1'b0;
        inst_req  = 1'b0;
        inst_addr = '0;
        cache_req = 1'b0;
        arready   = 1'b0;
        rdata     = '0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        for (int s = 0; s < 128; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        // Sweep keeps the fetch port closed
        repeat (128) begin
            @(posedge clk);
            if (inst_addr_ok || arvalid) begin
                $display("** Error at %0t: inst_addr_ok = %b, arvalid = %b, expected 0 in sweep",
                         $time, inst_addr_ok, arvalid);
                errors++;
            end
        end
        @(posedge clk);
        if (!inst_addr_ok) begin
            $display("** Error at %0t: inst_addr_ok = 0, expected 1 after sweep", $time);
            errors++;
        end

        ////////////////////////////////////////
        // Fetch, invalidate and checks
        ////////////////////////////////////////
        while (!(issued == N_FETCH && q_addr.size() == 0 && !inst_req && !cache_req &&
                 !want_inval)) begin
            @(posedge clk);
            cyc++;
            acc = inst_req && inst_addr_ok;
            serve_read_bus();
            if (arvalid && arready) begin
                if (q_addr.size() == 0 || q_hit[0] || ar_seen) begin
                    $display("** Error at %0t: read request without a predicted miss", $time);
                    errors++;
                end else if (araddr != {q_addr[0][31:2], 2'b00}) begin
                    $display("** Error at %0t: araddr = %h, expected %h", $time, araddr,
                             {q_addr[0][31:2], 2'b00});
                    errors++;
                end
                ar_seen = 1'b1;
                bursts++;
            end
            if (q_addr.size() != 0 && q_hit[0] && cyc == q_cyc[0] + 1 && !inst_data_ok) begin
                $display("** Error at %0t: inst_data_ok = 0, expected 1 for a hit", $time);
                errors++;
            end
            if (inst_data_ok) begin
                if (q_addr.size() == 0) begin
                    $display("** Error at %0t: inst_data_ok with no fetch outstanding", $time);
                    errors++;
                end else begin
                    addr    = q_addr.pop_front();
                    hit     = q_hit.pop_front();
                    acc_cyc = q_cyc.pop_front();
                    if (inst_rdata != mem_word(addr)) begin
                        $display("** Error at %0t: inst_rdata = %h, expected %h", $time,
                                 inst_rdata, mem_word(addr));
                        errors++;
                    end
                    if (hit && cyc != acc_cyc + 1) begin
                        $display("** Error at %0t: hit answered %0d cycles after acceptance",
                                 $time, cyc - acc_cyc);
                        errors++;
                    end
                    if (!hit && !ar_seen) begin
                        $display("** Error at %0t: miss answered without a read burst", $time);
                        errors++;
                    end else if (!hit && beats != 8) begin
                        $display("** Error at %0t: burst beats = %0d, expected 8", $time, beats);
                        errors++;
                    end
                    ar_seen = 1'b0;
                end
            end
            if (acc) begin
                hit = model_access(inst_addr);
                if (!hit) begin
                    misses++;
                end
                q_addr.push_back(inst_addr);
                q_hit.push_back(hit);
                q_cyc.push_back(cyc);
                inst_req <= 1'b0;
                if (issued % INVAL_GAP == 0) begin
                    want_inval = 1'b1;
                end
            end
            if (cache_op_ok && !cache_req) begin
                $display("** Error at %0t: cache_op_ok without a maintenance request", $time);
                errors++;
            end
            if (cache_req) begin
                if (cache_op_ok) begin
                    // Sampled on the first edge, pulse two cycles later
                    if (cyc - inval_cyc != 3) begin
                        $display("** Error at %0t: cache_op_ok came %0d cycles after sampling",
                                 $time, cyc - inval_cyc - 1);
                        errors++;
                    end
                    cache_req <= 1'b0;
                    want_inval = 1'b0;
                    invals++;
                end
            end else if (want_inval) begin
                if (q_addr.size() == 0 && !inst_req) begin
                    op = {18'($urandom), 2'($urandom), 7'(($urandom % 4) * 29), 5'b0};
                    m_valid[op[11:5]][op[13:12]] = 1'b0;
                    inst_addr <= op;
                    cache_req <= 1'b1;
                    inval_cyc = cyc;
                end
            end else if (issued < N_FETCH && (acc || !inst_req)) begin
                if ($urandom % 4 != 0) begin
                    inst_req  <= 1'b1;
                    inst_addr <= fetch_addr();
                    issued++;
                end
            end
        end

        if (bursts != misses) begin
            $display("** Error at %0t: read bursts = %0d, expected %0d", $time, bursts, misses);
            errors++;
        end
        $display("fetches %0d, misses %0d, bursts %0d, invalidates %0d, errors %0d",
                 issued, misses, bursts, invals, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_plru.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f filelist.f --top-module icache_tb -o icache_sim
out=$(./obj_dir/icache_sim)
echo "$out"
if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
